//--- Makefile
# Verilator build and run of the RV32I pipeline testbench

VERILATOR ?= verilator
TOP ?= tb_rv32_core
FLIST ?= rv32i_pipeline.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= TEST OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and pass only if the output has the pass line"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- rv32i_pipeline.f
+incdir+testbench
verilog/rv32_pkg.sv
verilog/core_interfaces.sv
verilog/fetch_unit.sv
verilog/decode_issue.sv
verilog/register_file.sv
verilog/alu_unit.sv
verilog/branch_unit.sv
verilog/rv32_core.sv
testbench/tb_rv32_core.sv

//--- testbench/tb_tests.svh
// Included inside tb_rv32_core; uses its encoders, loaders and reference model
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

localparam int RAND_OPS = 16;
//Words per program, in test order
localparam int PROGRAM_WORDS = 11 + 5 + 13 + 21 + 13 + (8 + RAND_OPS + 1);

task automatic imm_ops_test();
    begin_program();
    put_ret(enc_i(OPC_OP_IMM, F3_ADD_SUB, 1, 0, 'h5a5), 1, 32'h0000_05a5);
    put_ret(enc_i(OPC_OP_IMM, F3_ADD_SUB, 2, 0, -16), 2, 32'hffff_fff0);
    put_ret(enc_i(OPC_OP_IMM, F3_SLT, 3, 2, 5), 3, 32'd1);
    put_ret(enc_i(OPC_OP_IMM, F3_SLTU, 4, 2, 5), 4, 32'd0);
    put_ret(enc_i(OPC_OP_IMM, F3_XOR, 5, 1, 'h0ff), 5, 32'h0000_055a);
    put_ret(enc_i(OPC_OP_IMM, F3_OR, 6, 1, 'h00f), 6, 32'h0000_05af);
    put_ret(enc_i(OPC_OP_IMM, F3_AND, 7, 1, 'h0f0), 7, 32'h0000_00a0);
    put_ret(enc_i(OPC_OP_IMM, F3_SLL, 8, 1, 4), 8, 32'h0000_5a50);
    put_ret(enc_i(OPC_OP_IMM, F3_SRL_SRA, 9, 2, 4), 9, 32'h0fff_ffff);
    //Bit 10 of the immediate selects the arithmetic shift
    put_ret(enc_i(OPC_OP_IMM, F3_SRL_SRA, 10, 2, 'h402), 10, 32'hffff_fffc);
    put(enc_j(0, 0));
    run_program("immediate ops");
endtask

task automatic upper_imm_test();
    begin_program();
    put_ret(enc_u(OPC_LUI, 1, 'h12345), 1, 32'h1234_5000);
    put_ret(enc_u(OPC_AUIPC, 2, 'h00010), 2, 32'h0001_0004);
    put_ret(enc_u(OPC_LUI, 3, 'hfffff), 3, 32'hffff_f000);
    put_ret(enc_u(OPC_AUIPC, 4, 'h80000), 4, 32'h8000_000c);
    put(enc_j(0, 0));
    run_program("upper immediates");
endtask

//Each op reads the result of the one before it
task automatic reg_ops_test();
    begin_program();
    put_ret(enc_i(OPC_OP_IMM, F3_ADD_SUB, 1, 0, 100), 1, 32'd100);
    put_ret(enc_i(OPC_OP_IMM, F3_ADD_SUB, 2, 0, -7), 2, 32'hffff_fff9);
    put_ret(enc_r(F3_ADD_SUB, 1'b0, 3, 1, 2), 3, 32'h0000_005d);
    put_ret(enc_r(F3_ADD_SUB, 1'b1, 4, 3, 1), 4, 32'hffff_fff9);
    put_ret(enc_r(F3_SLT, 1'b0, 5, 4, 3), 5, 32'd1);
    put_ret(enc_r(F3_SLTU, 1'b0, 6, 4, 3), 6, 32'd0);
    put_ret(enc_r(F3_AND, 1'b0, 7, 3, 4), 7, 32'h0000_0059);
    put_ret(enc_r(F3_OR, 1'b0, 8, 7, 2), 8, 32'hffff_fff9);
    put_ret(enc_r(F3_XOR, 1'b0, 9, 8, 3), 9, 32'hffff_ffa4);
    put_ret(enc_r(F3_SLL, 1'b0, 10, 9, 5), 10, 32'hffff_ff48);
    put_ret(enc_r(F3_SRL_SRA, 1'b0, 11, 10, 5), 11, 32'h7fff_ffa4);
    put_ret(enc_r(F3_SRL_SRA, 1'b1, 12, 10, 5), 12, 32'hffff_ffa4);
    put(enc_j(0, 0));
    run_program("dependent register ops");
endtask

task automatic branch_test();
    begin_program();
    put_ret(enc_i(OPC_OP_IMM, F3_ADD_SUB, 1, 0, 5), 1, 32'd5);
    put_ret(enc_i(OPC_OP_IMM, F3_ADD_SUB, 2, 0, -3), 2, 32'hffff_fffd);
    put_skip(enc_b(F3_BEQ, 1, 1, 8), 1);
    put_skip(enc_b(F3_BNE, 1, 2, 8), 2);
    put_skip(enc_b(F3_BLT, 2, 1, 8), 3);
    put_skip(enc_b(F3_BGE, 1, 2, 8), 4);
    put_skip(enc_b(F3_BLTU, 1, 2, 8), 5);
    put_skip(enc_b(F3_BGEU, 2, 1, 8), 6);
    //Not taken, the next word retires
    put(enc_b(F3_BEQ, 1, 2, 8));
    put_ret(enc_i(OPC_OP_IMM, F3_ADD_SUB, 3, 0, 7), 3, 32'd7);
    put(enc_b(F3_BLT, 1, 2, 8));
    put_ret(enc_i(OPC_OP_IMM, F3_ADD_SUB, 4, 0, 8), 4, 32'd8);
    put(enc_b(F3_BLTU, 2, 1, 8));
    put_ret(enc_i(OPC_OP_IMM, F3_ADD_SUB, 5, 0, 9), 5, 32'd9);
    put(enc_j(0, 0));
    run_program("branches");
endtask

task automatic jump_test();
    begin_program();
    put_ret(enc_j(1, 12), 1, 32'd4);
    put(enc_i(OPC_OP_IMM, F3_ADD_SUB, 31, 0, 1));
    put(enc_i(OPC_OP_IMM, F3_ADD_SUB, 31, 0, 2));
    put_ret(enc_i(OPC_OP_IMM, F3_ADD_SUB, 2, 0, 28), 2, 32'd28);
    //Target 29 loses bit 0
    put_ret(enc_i(OPC_JALR, 3'b000, 3, 2, 1), 3, 32'd20);
    put(enc_i(OPC_OP_IMM, F3_ADD_SUB, 31, 0, 3));
    put(enc_i(OPC_OP_IMM, F3_ADD_SUB, 31, 0, 4));
    put_skip(enc_j(0, 8), 5);
    put_skip(enc_i(OPC_JALR, 3'b000, 0, 2, 16), 6);
    put_ret(enc_i(OPC_OP_IMM, F3_ADD_SUB, 4, 1, 1), 4, 32'd5);
    put(enc_j(0, 0));
    run_program("jumps");
endtask

task automatic random_ops_test();
    word_t model_regs [32];
    word_t value;
    word_t upper;
    int rd;
    int rs1;
    int rs2;
    logic [2:0] f3;
    logic alt;
    begin_program();
    //Operands in x1 to x4 built from LUI and ADDI
    for (int k = 1; k <= 4; k++) begin
        value = $urandom();
        upper = (value + 32'h800) & 32'hffff_f000;
        put_ret(enc_u(OPC_LUI, k, int'(upper[31:12])), k, upper);
        put_ret(enc_i(OPC_OP_IMM, F3_ADD_SUB, k, k, int'(value[11:0])), k, value);
        model_regs[k] = value;
    end
    for (int i = 0; i < RAND_OPS; i++) begin
        rd = 5 + i;
        rs1 = 1 + int'($urandom() % (rd - 1));
        rs2 = 1 + int'($urandom() % (rd - 1));
        f3 = 3'($urandom());
        alt = (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) ? 1'($urandom()) : 1'b0;
        value = model_op(f3, alt, model_regs[rs1], model_regs[rs2]);
        model_regs[rd] = value;
        put_ret(enc_r(f3, alt, rd, rs1, rs2), rd, value);
    end
    put(enc_j(0, 0));
    run_program("random register ops");
endtask

`endif

//--- testbench/tb_rv32_core.sv
// Instruction memory holds 256 words from address 0; every program must end in a self-loop
`timescale 1ns/1ps

module tb_rv32_core;
    import rv32_pkg::*;

    localparam int IMEM_WORDS = 256;
    localparam int IMEM_INDEX_BITS = $clog2(IMEM_WORDS);
    localparam int RESET_CYCLES = 4;
    //Quiet cycles after the last expected retire
    localparam int DRAIN_CYCLES = 8;

    typedef struct packed {
        reg_addr_t rd;
        word_t data;
        addr_t pc;
    } retire_t;

    logic clk = 1'b0;
    logic arst_n = 1'b0;
    addr_t imem_addr;
    word_t imem_data = '0;
    logic retire_valid;
    reg_addr_t retire_rd;
    word_t retire_data;
    addr_t retire_pc;

    word_t imem [IMEM_WORDS];
    retire_t seen_q [$];
    retire_t expect_q [$];
    int load_ptr = 0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    rv32_core dut (
        .clk (clk),
        .arst_n (arst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .retire_valid (retire_valid),
        .retire_rd (retire_rd),
        .retire_data (retire_data),
        .retire_pc (retire_pc)
    );

    always #5 clk = ~clk;

    //Synchronous instruction memory
    always @(posedge clk) begin
        imem_data <= imem[imem_addr[IMEM_INDEX_BITS+1:2]];
    end

    //Retire monitor
    always @(posedge clk) begin
        if (arst_n && retire_valid) begin
            assert (retire_rd != '0)
            else begin
                errors++;
                $display("** Error @%0t: retire reported a write to x0 at pc %h",
                         $time, retire_pc);
            end
            seen_q.push_back({retire_rd, retire_data, retire_pc});
        end
    end

    //////////////////////////////
    //Instruction encoders
    function automatic word_t enc_r(logic [2:0] f3, logic alt, int rd, int rs1, int rs2);
        return {1'b0, alt, 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic word_t enc_i(opcode_t opc, logic [2:0] f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t enc_u(opcode_t opc, int rd, int imm);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic word_t enc_b(logic [2:0] f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    //RV32I register-register semantics
    function automatic word_t model_op(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            F3_ADD_SUB: return alt ? a - b : a + b;
            F3_SLL: return a << b[4:0];
            F3_SLT: return {31'b0, $signed(a) < $signed(b)};
            F3_SLTU: return {31'b0, a < b};
            F3_XOR: return a ^ b;
            F3_SRL_SRA: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            F3_OR: return a | b;
            default: return a & b;
        endcase
    endfunction

    //////////////////////////////
    //Program loading and checking
    task automatic begin_program();
        @(posedge clk);
        arst_n <= 1'b0;
        //Address-tagged no-ops behind the program
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] <= enc_i(OPC_OP_IMM, F3_ADD_SUB, 0, 0, i);
        end
        load_ptr = 0;
        expect_q.delete();
    endtask

    task automatic put(word_t instr);
        imem[load_ptr] <= instr;
        load_ptr++;
    endtask

    task automatic put_ret(word_t instr, int rd, word_t value);
        expect_q.push_back({rd[4:0], value, addr_t'(load_ptr * 4)});
        put(instr);
    endtask

    //A taken branch or jump followed by a marker write that must never retire
    task automatic put_skip(word_t jump, int tag);
        put(jump);
        put(enc_i(OPC_OP_IMM, F3_ADD_SUB, 31, 0, tag));
    endtask

    task automatic run_program(string name);
        repeat (RESET_CYCLES) @(posedge clk);
        seen_q.delete();
        arst_n <= 1'b1;
        while (seen_q.size() < expect_q.size()) begin
            @(posedge clk);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);
        checks++;
        assert (seen_q.size() == expect_q.size())
        else begin
            errors++;
            $display("** Error @%0t: %s retired %0d instructions, expected %0d",
                     $time, name, seen_q.size(), expect_q.size());
        end
        for (int i = 0; i < expect_q.size() && i < seen_q.size(); i++) begin
            checks++;
            assert (seen_q[i] == expect_q[i])
            else begin
                errors++;
                $display("** Error @%0t: %s retire %0d is x%0d=%h at pc %h, expected x%0d=%h at pc %h",
                         $time, name, i, seen_q[i].rd, seen_q[i].data, seen_q[i].pc,
                         expect_q[i].rd, expect_q[i].data, expect_q[i].pc);
            end
        end
    endtask

    `include "tb_tests.svh"

    localparam int TIMEOUT_CYCLES = 4 * PROGRAM_WORDS + 200;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h56a));
        imm_ops_test();
        upper_imm_test();
        reg_ops_test();
        branch_test();
        jump_test();
        random_ops_test();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/alu_unit.sv
// One-cycle ALU; the only writeback source, so results retire in issue order
`timescale 1ns/1ps

module alu_unit (
    input  logic clk,
    input  logic arst_n,
    issue_if.unit issue,
    wb_if.source wb
);
    import rv32_pkg::*;

    word_t a;
    word_t b;
    logic [4:0] shamt;
    word_t result;

    assign a = issue.rs1_val;
    assign b = issue.rs2_val;
    assign shamt = b[4:0];

    always_comb begin
        case (issue.alu_op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_SLL: result = a << shamt;
            ALU_SLT: result = word_t'($signed(a) < $signed(b));
            ALU_SLTU: result = word_t'(a < b);
            ALU_XOR: result = a ^ b;
            ALU_SRL: result = a >> shamt;
            ALU_SRA: result = word_t'($signed(a) >>> shamt);
            ALU_OR: result = a | b;
            ALU_AND: result = a & b;
            ALU_LUI: result = issue.imm;
            ALU_AUIPC: result = issue.pc + issue.imm;
            //Return address of JAL and JALR
            ALU_LINK: result = issue.pc + 32'd4;
            default: result = '0;
        endcase
    end

    //////////////////////////////
    //Writeback stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= issue.valid && issue.alu_op != ALU_NONE && issue.rd != '0;
        end
    end

    always_ff @(posedge clk) begin
        wb.rd <= issue.rd;
        wb.data <= result;
        wb.pc <= issue.pc;
    end

    wb_follows_issue: assert property (@(posedge clk) disable iff (!arst_n)
        wb.valid |-> wb.rd != '0 && $past(issue.valid))
        else $error("writeback without a preceding issue or to x0");

endmodule

//--- verilog/branch_unit.sv
// Resolves branches and jumps at issue; target alignment is not checked here
`timescale 1ns/1ps

module branch_unit (
    input  logic clk,
    input  logic arst_n,
    issue_if.unit issue,
    output logic branch_flush,
    output rv32_pkg::addr_t branch_target
);
    import rv32_pkg::*;

    word_t a;
    word_t b;
    logic taken;
    addr_t jalr_sum;
    addr_t target;

    assign a = issue.rs1_val;
    assign b = issue.rs2_val;

    always_comb begin
        case (issue.br_op)
            BR_BEQ: taken = a == b;
            BR_BNE: taken = a != b;
            BR_BLT: taken = $signed(a) < $signed(b);
            BR_BGE: taken = $signed(a) >= $signed(b);
            BR_BLTU: taken = a < b;
            BR_BGEU: taken = a >= b;
            BR_JAL, BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    //JALR clears bit 0 of the sum
    assign jalr_sum = a + issue.imm;
    assign target = (issue.br_op == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                             : issue.pc + issue.imm;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            branch_flush <= 1'b0;
        end else begin
            branch_flush <= issue.valid && taken;
        end
    end

    always_ff @(posedge clk) begin
        branch_target <= target;
    end

endmodule

//--- verilog/core_interfaces.sv
// Internal pipeline links; plain levels and strobes, hold is the only back-pressure
`timescale 1ns/1ps

//Fetched word towards decode
interface fetch_if;
    import rv32_pkg::*;

    logic valid;
    addr_t pc;
    word_t instr;
    logic hold;

    modport fetch (output valid, output pc, output instr, input hold);
    modport decode (input valid, input pc, input instr, output hold);
endinterface

//Decoded instruction towards ALU and branch unit
interface issue_if;
    import rv32_pkg::*;

    logic valid;
    alu_op_t alu_op;
    br_op_t br_op;
    word_t rs1_val;
    word_t rs2_val;
    word_t imm;
    addr_t pc;
    reg_addr_t rd;

    modport issuer (
        output valid, output alu_op, output br_op, output rs1_val,
        output rs2_val, output imm, output pc, output rd
    );
    modport unit (
        input valid, input alu_op, input br_op, input rs1_val,
        input rs2_val, input imm, input pc, input rd
    );
endinterface

//Single writeback port, valid only for rd other than x0
interface wb_if;
    import rv32_pkg::*;

    logic valid;
    reg_addr_t rd;
    word_t data;
    addr_t pc;

    modport source (output valid, output rd, output data, output pc);
    modport sink (input valid, input rd, input data, input pc);
endinterface

//--- verilog/decode_issue.sv
// Unknown opcodes issue as no-ops; a one-cycle stall on a match with the previous rd
`timescale 1ns/1ps

module decode_issue (
    input  logic clk,
    input  logic arst_n,
    fetch_if.decode fetch,
    issue_if.issuer issue,
    output rv32_pkg::reg_addr_t rs1_addr,
    output rv32_pkg::reg_addr_t rs2_addr,
    input  rv32_pkg::word_t rs1_data,
    input  rv32_pkg::word_t rs2_data,
    input  logic branch_flush
);
    import rv32_pkg::*;

    word_t instr;
    opcode_t opcode;
    logic [2:0] funct3;
    logic funct7_alt;
    word_t imm_i;
    word_t imm_u;
    word_t imm_b;
    word_t imm_j;
    word_t imm;
    alu_op_t alu_op;
    br_op_t br_op;
    logic rs1_used;
    logic rs2_used;
    logic op2_imm;
    reg_addr_t issue_rd;
    reg_addr_t last_rd;
    logic stall;
    logic issue_fire;

    function automatic alu_op_t decode_alu(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL: return ALU_SLL;
            F3_SLT: return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR: return ALU_XOR;
            F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    //////////////////////////////
    //Fields and immediates
    assign instr = fetch.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7_alt = instr[30];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        alu_op = ALU_NONE;
        br_op = BR_NONE;
        imm = imm_i;
        rs1_used = 1'b0;
        rs2_used = 1'b0;
        op2_imm = 1'b0;
        case (opcode)
            OPC_OP: begin
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                alu_op = decode_alu(funct3, funct7_alt);
            end
            OPC_OP_IMM: begin
                rs1_used = 1'b1;
                op2_imm = 1'b1;
                //Bit 30 is part of the immediate except on right shifts
                alu_op = decode_alu(funct3, funct7_alt && funct3 == F3_SRL_SRA);
            end
            OPC_LUI: begin
                alu_op = ALU_LUI;
                imm = imm_u;
            end
            OPC_AUIPC: begin
                alu_op = ALU_AUIPC;
                imm = imm_u;
            end
            OPC_JAL: begin
                alu_op = ALU_LINK;
                br_op = BR_JAL;
                imm = imm_j;
            end
            OPC_JALR: begin
                rs1_used = 1'b1;
                alu_op = ALU_LINK;
                br_op = BR_JALR;
            end
            OPC_BRANCH: begin
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                imm = imm_b;
                case (funct3)
                    F3_BEQ: br_op = BR_BEQ;
                    F3_BNE: br_op = BR_BNE;
                    F3_BLT: br_op = BR_BLT;
                    F3_BGE: br_op = BR_BGE;
                    F3_BLTU: br_op = BR_BLTU;
                    F3_BGEU: br_op = BR_BGEU;
                    default: br_op = BR_NONE;
                endcase
            end
            default: begin
            end
        endcase
    end

    //Only ALU results are written back
    assign issue_rd = (alu_op != ALU_NONE) ? instr[11:7] : '0;

    //////////////////////////////
    //Hazard and issue
    assign stall = (rs1_used && rs1_addr != '0 && rs1_addr == last_rd) ||
                   (rs2_used && rs2_addr != '0 && rs2_addr == last_rd);
    assign fetch.hold = fetch.valid && stall && !branch_flush;
    assign issue_fire = fetch.valid && !stall && !branch_flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_rd <= '0;
        end else begin
            last_rd <= issue_fire ? issue_rd : '0;
        end
    end

    assign issue.valid = issue_fire;
    assign issue.alu_op = alu_op;
    assign issue.br_op = br_op;
    assign issue.rs1_val = rs1_data;
    assign issue.rs2_val = op2_imm ? imm : rs2_data;
    assign issue.imm = imm;
    assign issue.pc = fetch.pc;
    assign issue.rd = issue_rd;

    //Squash the word in decode and the one behind it
    flush_squash: assert property (@(posedge clk) disable iff (!arst_n)
        branch_flush |-> !issue.valid ##1 !fetch.valid)
        else $error("instruction issued on the wrong path after a branch flush");

endmodule

//--- verilog/fetch_unit.sv
// Predicts not-taken; instruction memory must return data one cycle after its address
`timescale 1ns/1ps

module fetch_unit (
    input  logic clk,
    input  logic arst_n,
    fetch_if.fetch fetch,
    output rv32_pkg::addr_t imem_addr,
    input  rv32_pkg::word_t imem_data,
    input  logic branch_flush,
    input  rv32_pkg::addr_t branch_target
);
    import rv32_pkg::*;

    addr_t pc_q;
    addr_t pc_prev_q;
    logic valid_q;

    //////////////////////////////
    //Next PC
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= RESET_PC;
            valid_q <= 1'b0;
        end else if (branch_flush) begin
            pc_q <= branch_target;
            //Word already in flight is from the wrong path
            valid_q <= 1'b0;
        end else if (!fetch.hold) begin
            pc_q <= pc_q + 32'd4;
            valid_q <= 1'b1;
        end
    end

    //Address of the word now coming out of memory
    always_ff @(posedge clk) begin
        if (!fetch.hold) begin
            pc_prev_q <= imem_addr;
        end
    end

    //On hold, read the word in decode once more
    assign imem_addr = fetch.hold ? pc_prev_q : pc_q;

    assign fetch.valid = valid_q;
    assign fetch.pc = pc_prev_q;
    assign fetch.instr = imem_data;

    //Redirect targets must keep fetch on word boundaries
    imem_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        imem_addr[1:0] == 2'b00)
        else $error("instruction fetch address not word aligned");

endmodule

//--- verilog/register_file.sv
// Single write port from the ALU; reads see a write of the same cycle
`timescale 1ns/1ps

module register_file (
    input  logic clk,
    input  logic arst_n,
    input  rv32_pkg::reg_addr_t rs1_addr,
    input  rv32_pkg::reg_addr_t rs2_addr,
    output rv32_pkg::word_t rs1_data,
    output rv32_pkg::word_t rs2_data,
    wb_if.sink wb
);
    import rv32_pkg::*;

    //x0 has no storage
    word_t regs [1:NUM_REGS-1];

    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wb.valid && wb.rd == addr) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

//--- verilog/rv32_core.sv
// In-order RV32I integer core; synchronous instruction memory, no data memory
`timescale 1ns/1ps

module rv32_core (
    input  logic clk,
    input  logic arst_n,
    output rv32_pkg::addr_t imem_addr,
    input  rv32_pkg::word_t imem_data,
    output logic retire_valid,
    output rv32_pkg::reg_addr_t retire_rd,
    output rv32_pkg::word_t retire_data,
    output rv32_pkg::addr_t retire_pc
);
    import rv32_pkg::*;

    fetch_if fetch ();
    issue_if issue ();
    wb_if wb ();

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t rs1_data;
    word_t rs2_data;
    logic branch_flush;
    addr_t branch_target;

    //////////////////////////////
    //Front end
    fetch_unit fetch_block (
        .clk (clk),
        .arst_n (arst_n),
        .fetch (fetch),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .branch_flush (branch_flush),
        .branch_target (branch_target)
    );

    decode_issue decode_issue_block (
        .clk (clk),
        .arst_n (arst_n),
        .fetch (fetch),
        .issue (issue),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .branch_flush (branch_flush)
    );

    register_file register_file_block (
        .clk (clk),
        .arst_n (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb (wb)
    );

    //////////////////////////////
    //Execution units
    alu_unit alu_unit_block (
        .clk (clk),
        .arst_n (arst_n),
        .issue (issue),
        .wb (wb)
    );

    branch_unit branch_unit_block (
        .clk (clk),
        .arst_n (arst_n),
        .issue (issue),
        .branch_flush (branch_flush),
        .branch_target (branch_target)
    );

    //Retire port mirrors writeback
    assign retire_valid = wb.valid;
    assign retire_rd = wb.rd;
    assign retire_data = wb.data;
    assign retire_pc = wb.pc;

endmodule

//--- verilog/rv32_pkg.sv
// RV32I integer subset only: no loads, stores, CSRs, MUL/DIV or compressed encodings
package rv32_pkg;

    //////////////////////////////
    //Widths
    localparam int XLEN = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;
    typedef logic [6:0] opcode_t;

    localparam addr_t RESET_PC = 32'h0000_0000;

    //////////////////////////////
    //Major opcodes
    localparam opcode_t OPC_OP = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI = 7'b0110111;
    localparam opcode_t OPC_AUIPC = 7'b0010111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL = 7'b1101111;
    localparam opcode_t OPC_JALR = 7'b1100111;

    //funct3 of OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    //funct3 of BRANCH
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    //////////////////////////////
    //Unit operations
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_LUI, ALU_AUIPC, ALU_LINK, ALU_NONE
    } alu_op_t;

    typedef enum logic [3:0] {
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU,
        BR_JAL, BR_JALR, BR_NONE
    } br_op_t;

endpackage
